// File: decode_imm_gen.sv
// Immediate extraction for the five RV32I formats
// Every immediate is sign extended from instruction bit 31

`timescale 1ns/100ps

module decode_imm_gen (
    input  decode_isa_pkg::instr_u   instr_i,
    output decode_uop_pkg::imm_set_t imm_o
);

    import decode_isa_pkg::*;

    logic        sign;
    logic [6:0]  hi;
    logic [4:0]  lo;
    logic [19:0] imm20;

    assign sign  = instr_i.rib.funct7[6];          // Bit 31
    assign hi    = instr_i.rib.funct7;             // Bits 31:25
    assign lo    = instr_i.rib.rd;                 // Bits 11:7
    assign imm20 = instr_i.uj.imm20;               // Bits 31:12

    //----------------------------------------
    // I and S formats
    //----------------------------------------

    assign imm_o.i = {{(XLEN-12){sign}}, hi, instr_i.rib.rs2};
    assign imm_o.s = {{(XLEN-12){sign}}, hi, lo};

    //----------------------------------------
    // B format
    //----------------------------------------

    // imm[12|10:5] in hi, imm[4:1|11] in lo
    assign imm_o.b = {{(XLEN-12){sign}}, lo[0], hi[5:0], lo[4:1], 1'b0};

    //----------------------------------------
    // U and J formats
    //----------------------------------------

    assign imm_o.u = {imm20, 12'b0};

    // imm[20|10:1|11|19:12] in imm20
    assign imm_o.j = {{(XLEN-20){sign}}, imm20[7:0], imm20[8], imm20[18:9], 1'b0};

endmodule

// File: decode_isa_pkg.sv
// RV32I instruction set definitions for the decode stage
// Widths, major opcodes, trap causes and the two views of an instruction word

package decode_isa_pkg;

    localparam int XLEN       = 32;             // Data and address width
    localparam int REG_ADDR_W = 5;              // Register address width

    // Major opcodes kept by this core
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    localparam logic [6:0] TRAP_IACCESS = 7'd1; // Fetch bus error
    localparam logic [6:0] TRAP_IOPCODE = 7'd2; // Illegal instruction

    // R, I, S and B formats share this layout
    typedef struct packed {
        logic [6:0] funct7;                     // imm_hi for S and B
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;                         // imm_lo for S and B
        logic [6:0] opcode;
    } instr_rib_t;

    // U and J formats
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_uj_t;

    typedef union packed {
        instr_rib_t rib;
        instr_uj_t  uj;
    } instr_u;

    typedef struct packed {
        instr_u instr;
        logic   ferr;                           // Fetch bus error
    } fetch_word_t;

endpackage

// File: decode_pc_track.sv
// Program counter of the word presented to decode
// Steps by 4 on each accepted word and loads the target on redirect

`timescale 1ns/100ps

module decode_pc_track #(
    parameter logic [decode_isa_pkg::XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000
) (
    input  logic                            g_clk,
    input  logic                            g_resetn,
    input  logic                            accept_i,          // Word taken this cycle
    input  logic                            redirect_i,        // Control flow change
    input  logic [decode_isa_pkg::XLEN-1:0] redirect_target_i,
    output logic [decode_isa_pkg::XLEN-1:0] pc_o,
    output logic [decode_isa_pkg::XLEN-1:0] npc_o
);

    import decode_isa_pkg::*;

    logic [XLEN-1:0] pc_q;

    assign pc_o  = pc_q;
    assign npc_o = pc_q + XLEN'(4);                 // Only 32-bit words

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (redirect_i) begin
            pc_q <= redirect_target_i;              // Redirect wins
        end else if (accept_i) begin
            pc_q <= npc_o;
        end
    end

endmodule

// File: decode_stage_buf.sv
// Two-entry in-order buffer between decode and execute
// Head entry drives the registered output, flush empties both entries

`timescale 1ns/100ps

module decode_stage_buf (
    input  logic                        g_clk,
    input  logic                        g_resetn,
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  decode_uop_pkg::decode_uop_t in_uop_i,
    input  logic                        flush_i,      // Drop all entries
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output decode_uop_pkg::decode_uop_t out_uop_o     // Head entry
);

    import decode_uop_pkg::*;

    logic [1:0]  count_q;                          // Entries held, 0 to 2
    decode_uop_t tail_q;                           // Second entry
    logic        push;
    logic        pop;

    assign in_ready_o  = (count_q != 2'd2) && !flush_i;
    assign out_valid_o = (count_q != 2'd0);
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            count_q <= 2'd0;
        end else if (flush_i) begin
            count_q <= 2'd0;
        end else begin
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    //----------------------------------------
    // Payload
    //----------------------------------------
    always_ff @(posedge g_clk) begin
        if (push && (count_q == 2'd0 || pop)) begin
            out_uop_o <= in_uop_i;                 // Straight to head
        end else if (push) begin
            tail_q <= in_uop_i;
        end else if (pop && count_q == 2'd2) begin
            out_uop_o <= tail_q;                   // Tail moves up
        end
    end

endmodule

// File: decode_top.sv
// Decode and operand gather stage of the RV32I core
// Fetch words in, register reads out, buffered micro-ops to execute

`timescale 1ns/100ps

module decode_top #(
    parameter logic [decode_isa_pkg::XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000
) (
    input  logic                                  g_clk,
    input  logic                                  g_resetn,
    input  logic                                  fetch_valid_i,
    output logic                                  fetch_ready_o,
    input  decode_isa_pkg::fetch_word_t           fetch_i,
    output logic [decode_isa_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [decode_isa_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [decode_isa_pkg::XLEN-1:0]       rs1_data_i,     // Forwarded
    input  logic [decode_isa_pkg::XLEN-1:0]       rs2_data_i,     // Forwarded
    input  logic                                  redirect_i,
    input  logic [decode_isa_pkg::XLEN-1:0]       redirect_target_i,
    output logic                                  uop_valid_o,
    input  logic                                  uop_ready_i,
    output decode_uop_pkg::decode_uop_t           uop_o
);

    import decode_isa_pkg::*;
    import decode_uop_pkg::*;

    logic            accept;                       // Fetch handshake
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] npc;
    imm_set_t        imm_set;
    decode_uop_t     uop_built;

    assign accept = fetch_valid_i && fetch_ready_o;

    decode_pc_track #(
        .PC_RESET_ADDR (PC_RESET_ADDR)
    ) u_pc_track (
        .g_clk             (g_clk),
        .g_resetn          (g_resetn),
        .accept_i          (accept),
        .redirect_i        (redirect_i),
        .redirect_target_i (redirect_target_i),
        .pc_o              (pc),
        .npc_o             (npc)
    );

    decode_imm_gen u_imm_gen (
        .instr_i (fetch_i.instr),
        .imm_o   (imm_set)
    );

    decode_uop_gen u_uop_gen (
        .fetch_i    (fetch_i),
        .pc_i       (pc),
        .npc_i      (npc),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .imm_i      (imm_set),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .uop_o      (uop_built)
    );

    decode_stage_buf u_stage_buf (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .in_valid_i  (fetch_valid_i),
        .in_ready_o  (fetch_ready_o),
        .in_uop_i    (uop_built),
        .flush_i     (redirect_i),                 // Redirect drops queued uops
        .out_valid_o (uop_valid_o),
        .out_ready_i (uop_ready_i),
        .out_uop_o   (uop_o)
    );

endmodule

// File: decode_uop_gen.sv
// Instruction classification and operand selection
// Builds one micro-op from the fetched word, the PC and the gathered operands

`timescale 1ns/100ps

module decode_uop_gen (
    input  decode_isa_pkg::fetch_word_t               fetch_i,
    input  logic [decode_isa_pkg::XLEN-1:0]           pc_i,
    input  logic [decode_isa_pkg::XLEN-1:0]           npc_i,
    input  logic [decode_isa_pkg::XLEN-1:0]           rs1_data_i,
    input  logic [decode_isa_pkg::XLEN-1:0]           rs2_data_i,
    input  decode_uop_pkg::imm_set_t                  imm_i,
    output logic [decode_isa_pkg::REG_ADDR_W-1:0]     rs1_addr_o,
    output logic [decode_isa_pkg::REG_ADDR_W-1:0]     rs2_addr_o,
    output decode_uop_pkg::decode_uop_t               uop_o
);

    import decode_isa_pkg::*;
    import decode_uop_pkg::*;

    instr_u     instr;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       illegal;                           // Unknown opcode or funct
    logic       use_imm;                           // ALU rhs from immediate

    assign instr      = fetch_i.instr;
    assign funct3     = instr.rib.funct3;
    assign funct7     = instr.rib.funct7;
    assign rs1_addr_o = instr.rib.rs1;             // Raw fields, even for I-type
    assign rs2_addr_o = instr.rib.rs2;

    always_comb begin
        uop_o          = '0;
        illegal        = 1'b0;
        use_imm        = 1'b0;
        uop_o.pc       = pc_i;
        uop_o.npc      = npc_i;
        uop_o.instr    = instr;
        uop_o.rd       = instr.rib.rd;
        uop_o.rs1_addr = rs1_addr_o;
        uop_o.rs2_addr = rs2_addr_o;

        //----------------------------------------
        // Major opcode decode
        //----------------------------------------
        case (instr.rib.opcode)
            OPC_LUI, OPC_AUIPC: begin
                uop_o.imm    = imm_i.u;
                use_imm      = 1'b1;
                uop_o.alu_op = ALU_ADD;            // lhs is zero or pc
                uop_o.wb_sel = WB_ALU;
            end
            OPC_JAL: begin
                uop_o.imm    = imm_i.j;
                uop_o.cfu_op = CFU_JAL;
                uop_o.wb_sel = WB_NPC;
            end
            OPC_JALR: begin
                illegal      = (funct3 != 3'b000);
                uop_o.imm    = imm_i.i;
                uop_o.cfu_op = CFU_JALR;
                uop_o.wb_sel = WB_NPC;
            end
            OPC_BRANCH: begin
                uop_o.imm    = imm_i.b;
                uop_o.alu_op = ALU_SUB;            // Compare by subtraction
                uop_o.rd     = '0;
                case (funct3)
                    3'b000:  uop_o.cfu_op = CFU_BEQ;
                    3'b001:  uop_o.cfu_op = CFU_BNE;
                    3'b100:  uop_o.cfu_op = CFU_BLT;
                    3'b101:  uop_o.cfu_op = CFU_BGE;
                    3'b110:  uop_o.cfu_op = CFU_BLTU;
                    3'b111:  uop_o.cfu_op = CFU_BGEU;
                    default: illegal      = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                illegal        = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
                uop_o.imm      = imm_i.i;
                use_imm        = 1'b1;
                uop_o.alu_op   = ALU_ADD;          // Address generation
                uop_o.lsu.load = 1'b1;
                uop_o.lsu.size = lsu_size_e'(funct3[1:0]);
                uop_o.lsu.sext = !funct3[2];       // lbu and lhu zero extend
                uop_o.wb_sel   = WB_LSU;
            end
            OPC_STORE: begin
                illegal         = funct3[2] || (funct3[1:0] == 2'b11);
                uop_o.imm       = imm_i.s;
                use_imm         = 1'b1;
                uop_o.alu_op    = ALU_ADD;
                uop_o.rd        = '0;
                uop_o.lsu.store = 1'b1;
                uop_o.lsu.size  = lsu_size_e'(funct3[1:0]);
            end
            OPC_OP_IMM: begin
                uop_o.imm    = imm_i.i;
                use_imm      = 1'b1;
                uop_o.wb_sel = WB_ALU;
                case (funct3)
                    3'b000: uop_o.alu_op = ALU_ADD;
                    3'b010: uop_o.alu_op = ALU_SLT;
                    3'b011: uop_o.alu_op = ALU_SLTU;
                    3'b100: uop_o.alu_op = ALU_XOR;
                    3'b110: uop_o.alu_op = ALU_OR;
                    3'b111: uop_o.alu_op = ALU_AND;
                    3'b001: begin
                        uop_o.alu_op = ALU_SLL;
                        illegal      = (funct7 != 7'b0000000);
                    end
                    default: begin                 // srli and srai
                        uop_o.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                        illegal      = ({funct7[6], funct7[4:0]} != 6'b0);
                    end
                endcase
            end
            OPC_OP: begin
                uop_o.wb_sel = WB_ALU;
                case ({funct7, funct3})
                    10'b0000000_000: uop_o.alu_op = ALU_ADD;
                    10'b0100000_000: uop_o.alu_op = ALU_SUB;
                    10'b0000000_001: uop_o.alu_op = ALU_SLL;
                    10'b0000000_010: uop_o.alu_op = ALU_SLT;
                    10'b0000000_011: uop_o.alu_op = ALU_SLTU;
                    10'b0000000_100: uop_o.alu_op = ALU_XOR;
                    10'b0000000_101: uop_o.alu_op = ALU_SRL;
                    10'b0100000_101: uop_o.alu_op = ALU_SRA;
                    10'b0000000_110: uop_o.alu_op = ALU_OR;
                    10'b0000000_111: uop_o.alu_op = ALU_AND;
                    default:         illegal      = 1'b1;
                endcase
            end
            default: illegal = 1'b1;
        endcase

        //----------------------------------------
        // Operands
        //----------------------------------------
        if (instr.rib.opcode == OPC_AUIPC) begin
            uop_o.alu_lhs = pc_i;
        end else if (instr.rib.opcode == OPC_LUI) begin
            uop_o.alu_lhs = '0;
        end else begin
            uop_o.alu_lhs = rs1_data_i;
        end
        uop_o.alu_rhs = use_imm ? uop_o.imm : rs2_data_i;

        //----------------------------------------
        // Traps
        //----------------------------------------
        if (fetch_i.ferr) begin
            uop_o.trap       = 1'b1;
            uop_o.trap_cause = TRAP_IACCESS;       // Fetch error beats decode
        end else if (illegal) begin
            uop_o.trap       = 1'b1;
            uop_o.trap_cause = TRAP_IOPCODE;
        end
        if (uop_o.trap) begin
            uop_o.lsu.load  = 1'b0;                // No side effects
            uop_o.lsu.store = 1'b0;
            uop_o.wb_sel    = WB_NONE;
        end
    end

endmodule

// File: decode_uop_pkg.sv
// Micro-op types passed from decode to the execute stage
// Operation encodings, load/store control and the packed micro-op

package decode_uop_pkg;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        CFU_NONE,
        CFU_BEQ,
        CFU_BNE,
        CFU_BLT,
        CFU_BGE,
        CFU_BLTU,
        CFU_BGEU,
        CFU_JAL,
        CFU_JALR
    } cfu_op_e;

    // Same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        LSU_BYTE = 2'd0,
        LSU_HALF = 2'd1,
        LSU_WORD = 2'd2
    } lsu_size_e;

    typedef struct packed {
        logic      load;
        logic      store;
        lsu_size_e size;
        logic      sext;                        // Sign extend loaded value
    } lsu_ctl_t;

    typedef enum logic [1:0] {
        WB_NONE,
        WB_ALU,
        WB_LSU,
        WB_NPC
    } wb_sel_e;

    typedef struct packed {
        logic [decode_isa_pkg::XLEN-1:0] i;
        logic [decode_isa_pkg::XLEN-1:0] s;
        logic [decode_isa_pkg::XLEN-1:0] b;
        logic [decode_isa_pkg::XLEN-1:0] u;
        logic [decode_isa_pkg::XLEN-1:0] j;
    } imm_set_t;

    typedef struct packed {
        logic [decode_isa_pkg::XLEN-1:0]       pc;
        logic [decode_isa_pkg::XLEN-1:0]       npc;
        decode_isa_pkg::instr_u                instr;
        logic [decode_isa_pkg::REG_ADDR_W-1:0] rd;
        logic [decode_isa_pkg::REG_ADDR_W-1:0] rs1_addr;
        logic [decode_isa_pkg::REG_ADDR_W-1:0] rs2_addr;
        logic [decode_isa_pkg::XLEN-1:0]       imm;
        logic [decode_isa_pkg::XLEN-1:0]       alu_lhs;
        logic [decode_isa_pkg::XLEN-1:0]       alu_rhs;   // Shift amount in [4:0]
        alu_op_e                               alu_op;
        cfu_op_e                               cfu_op;
        lsu_ctl_t                              lsu;
        wb_sel_e                               wb_sel;
        logic                                  trap;
        logic [6:0]                            trap_cause;
    } decode_uop_t;

endpackage

// File: src.f
+incdir+.
decode_isa_pkg.sv
decode_uop_pkg.sv
decode_pc_track.sv
decode_imm_gen.sv
decode_uop_gen.sv
decode_stage_buf.sv
decode_top.sv
tb_clock_gen.sv
tb_decode_top.sv

// File: tb_clock_gen.sv
// Testbench clock and reset generator
// Free running clock, active low reset held for a few cycles

`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2;
        resetn_o = 1'b1;                           // Released just after an edge
    end

endmodule

// File: tb_decode_ref.svh
// Reference decode model for the decode stage testbench
// Expected micro-op from the raw RV32I word, the PC and the operand values

`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

function automatic decode_uop_t ref_decode(
    input fetch_word_t fw,
    input logic [31:0] pc,
    input logic [31:0] rs1_val,
    input logic [31:0] rs2_val
);
    decode_uop_t u;
    logic [31:0] w;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        bad;
    logic        imm_rhs;

    w          = fw.instr;
    f3         = w[14:12];
    f7         = w[31:25];
    u          = '0;
    bad        = 1'b0;
    imm_rhs    = 1'b0;
    u.pc       = pc;
    u.npc      = pc + 32'd4;
    u.instr    = fw.instr;
    u.rd       = w[11:7];
    u.rs1_addr = w[19:15];
    u.rs2_addr = w[24:20];
    u.alu_lhs  = rs1_val;

    case (w[6:0])
        OPC_LUI, OPC_AUIPC: begin
            u.imm     = {w[31:12], 12'h000};
            u.alu_lhs = (w[6:0] == OPC_AUIPC) ? pc : 32'h0;
            imm_rhs   = 1'b1;
            u.alu_op  = ALU_ADD;
            u.wb_sel  = WB_ALU;
        end
        OPC_JAL: begin
            u.imm    = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            u.cfu_op = CFU_JAL;
            u.wb_sel = WB_NPC;
        end
        OPC_JALR: begin
            bad      = (f3 != 3'b000);
            u.imm    = {{20{w[31]}}, w[31:20]};
            u.cfu_op = CFU_JALR;
            u.wb_sel = WB_NPC;
        end
        OPC_BRANCH: begin
            u.imm    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            u.alu_op = ALU_SUB;
            u.rd     = '0;
            case (f3)
                3'd0:    u.cfu_op = CFU_BEQ;
                3'd1:    u.cfu_op = CFU_BNE;
                3'd4:    u.cfu_op = CFU_BLT;
                3'd5:    u.cfu_op = CFU_BGE;
                3'd6:    u.cfu_op = CFU_BLTU;
                3'd7:    u.cfu_op = CFU_BGEU;
                default: bad = 1'b1;
            endcase
        end
        OPC_LOAD: begin
            bad        = (f3 == 3'd3) || (f3 > 3'd5);
            u.imm      = {{20{w[31]}}, w[31:20]};
            imm_rhs    = 1'b1;
            u.alu_op   = ALU_ADD;
            u.lsu.load = 1'b1;
            u.lsu.size = lsu_size_e'(f3[1:0]);
            u.lsu.sext = ~f3[2];                   // lb, lh, lw
            u.wb_sel   = WB_LSU;
        end
        OPC_STORE: begin
            bad         = (f3 > 3'd2);
            u.imm       = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_rhs     = 1'b1;
            u.alu_op    = ALU_ADD;
            u.rd        = '0;
            u.lsu.store = 1'b1;
            u.lsu.size  = lsu_size_e'(f3[1:0]);
        end
        OPC_OP_IMM: begin
            u.imm    = {{20{w[31]}}, w[31:20]};
            imm_rhs  = 1'b1;
            u.wb_sel = WB_ALU;
            case (f3)
                3'd0: u.alu_op = ALU_ADD;
                3'd2: u.alu_op = ALU_SLT;
                3'd3: u.alu_op = ALU_SLTU;
                3'd4: u.alu_op = ALU_XOR;
                3'd6: u.alu_op = ALU_OR;
                3'd7: u.alu_op = ALU_AND;
                3'd1: begin
                    u.alu_op = ALU_SLL;
                    bad      = (f7 != 7'h00);
                end
                default: begin
                    u.alu_op = (f7 == 7'h20) ? ALU_SRA : ALU_SRL;
                    bad      = !(f7 inside {7'h00, 7'h20});
                end
            endcase
        end
        OPC_OP: begin
            u.wb_sel = WB_ALU;
            if (f7 == 7'h00) begin
                case (f3)
                    3'd0: u.alu_op = ALU_ADD;
                    3'd1: u.alu_op = ALU_SLL;
                    3'd2: u.alu_op = ALU_SLT;
                    3'd3: u.alu_op = ALU_SLTU;
                    3'd4: u.alu_op = ALU_XOR;
                    3'd5: u.alu_op = ALU_SRL;
                    3'd6: u.alu_op = ALU_OR;
                    3'd7: u.alu_op = ALU_AND;
                endcase
            end else if (f7 == 7'h20 && f3 == 3'd0) begin
                u.alu_op = ALU_SUB;
            end else if (f7 == 7'h20 && f3 == 3'd5) begin
                u.alu_op = ALU_SRA;
            end else begin
                bad = 1'b1;
            end
        end
        default: bad = 1'b1;
    endcase

    u.alu_rhs = imm_rhs ? u.imm : rs2_val;

    if (fw.ferr) begin
        u.trap       = 1'b1;
        u.trap_cause = 7'd1;
    end else if (bad) begin
        u.trap       = 1'b1;
        u.trap_cause = 7'd2;
    end
    if (u.trap) begin
        u.lsu.load  = 1'b0;
        u.lsu.store = 1'b0;
        u.wb_sel    = WB_NONE;
    end
    return u;
endfunction

`endif

// File: tb_decode_top.sv
// Testbench for the RV32I decode stage
// Random fetch words, register model, back-pressure and redirects
// Expected micro-ops are queued on accept and compared on output handshake

`timescale 1ns/100ps

module tb_decode_top;

    import decode_isa_pkg::*;
    import decode_uop_pkg::*;

    `include "tb_decode_ref.svh"

    localparam logic [31:0] RESET_PC       = 32'h1000_0000;
    localparam int          PHASE_CYCLES   = 160;
    localparam int          STIM_CYCLES    = 3 * PHASE_CYCLES;
    localparam int          TIMEOUT_CYCLES = 4 * STIM_CYCLES + 200;

    logic        g_clk;
    logic        g_resetn;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_word_t fetch_word;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        redirect;
    logic [31:0] redirect_target;
    logic        uop_valid;
    logic        uop_ready;
    decode_uop_t uop;

    logic [31:0] regs [32];                        // Register model
    logic [31:0] fetch_bits;
    decode_uop_t exp_q[$];                         // Expected micro-ops in order
    decode_uop_t exp_uop;
    logic [31:0] exp_pc;
    bit          fetch_taken;                      // Handshake seen at last negedge
    int          errors;
    int          checks;
    int          n_out;
    int          cycle_cnt;

    assign rs1_data   = regs[rs1_addr];
    assign rs2_data   = regs[rs2_addr];
    assign fetch_bits = fetch_word.instr;

    tb_clock_gen #(
        .PERIOD_NS    (40),
        .RESET_CYCLES (4)
    ) u_clock_gen (
        .clk_o    (g_clk),
        .resetn_o (g_resetn)
    );

    decode_top uut (
        .g_clk             (g_clk),
        .g_resetn          (g_resetn),
        .fetch_valid_i     (fetch_valid),
        .fetch_ready_o     (fetch_ready),
        .fetch_i           (fetch_word),
        .rs1_addr_o        (rs1_addr),
        .rs2_addr_o        (rs2_addr),
        .rs1_data_i        (rs1_data),
        .rs2_data_i        (rs2_data),
        .redirect_i        (redirect),
        .redirect_target_i (redirect_target),
        .uop_valid_o       (uop_valid),
        .uop_ready_i       (uop_ready),
        .uop_o             (uop)
    );

    //----------------------------------------
    // Checks
    //----------------------------------------
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_uop(input decode_uop_t e, input decode_uop_t a, input int idx);
        string tag;
        tag = $sformatf("uop %0d", idx);
        check_eq({tag, " pc"}, e.pc, a.pc);
        check_eq({tag, " npc"}, e.npc, a.npc);
        check_eq({tag, " instr"}, e.instr, a.instr);
        check_eq({tag, " trap"}, e.trap, a.trap);
        check_eq({tag, " trap_cause"}, e.trap_cause, a.trap_cause);
        check_eq({tag, " load"}, e.lsu.load, a.lsu.load);
        check_eq({tag, " store"}, e.lsu.store, a.lsu.store);
        check_eq({tag, " wb_sel"}, e.wb_sel, a.wb_sel);
        if (!e.trap) begin                         // Rest undefined on a trap
            check_eq({tag, " rd"}, e.rd, a.rd);
            check_eq({tag, " rs1_addr"}, e.rs1_addr, a.rs1_addr);
            check_eq({tag, " rs2_addr"}, e.rs2_addr, a.rs2_addr);
            check_eq({tag, " imm"}, e.imm, a.imm);
            check_eq({tag, " alu_lhs"}, e.alu_lhs, a.alu_lhs);
            check_eq({tag, " alu_rhs"}, e.alu_rhs, a.alu_rhs);
            check_eq({tag, " alu_op"}, e.alu_op, a.alu_op);
            check_eq({tag, " cfu_op"}, e.cfu_op, a.cfu_op);
            check_eq({tag, " lsu_size"}, e.lsu.size, a.lsu.size);
            check_eq({tag, " lsu_sext"}, e.lsu.sext, a.lsu.sext);
        end
    endtask

    //----------------------------------------
    // Stimulus
    //----------------------------------------
    // Template pool with illegal words in kinds 10 and 11
    function automatic logic [31:0] make_word(input int unsigned kind, input logic [31:0] r,
                                              input logic [31:0] pick);
        logic [31:0] w;
        logic [2:0]  f3;
        w = r;
        case (kind)
            0:  w[6:0] = OPC_LUI;
            1:  w[6:0] = OPC_AUIPC;
            2:  w[6:0] = OPC_JAL;
            3:  w[14:0] = {3'b000, r[11:7], OPC_JALR};
            4: begin
                f3 = 3'(pick % 6);
                if (f3 >= 3'd2) f3 = f3 + 3'd2;    // 0 1 4 5 6 7
                w[14:12] = f3;
                w[6:0]   = OPC_BRANCH;
            end
            5: begin
                f3 = 3'(pick % 5);
                if (f3 >= 3'd3) f3 = f3 + 3'd1;    // 0 1 2 4 5
                w[14:12] = f3;
                w[6:0]   = OPC_LOAD;
            end
            6: begin
                w[14:12] = 3'(pick % 3);
                w[6:0]   = OPC_STORE;
            end
            7: begin
                f3 = 3'(pick % 6);
                if (f3 >= 3'd1) f3 = f3 + 3'd1;
                if (f3 >= 3'd5) f3 = f3 + 3'd1;    // 0 2 3 4 6 7
                w[14:12] = f3;
                w[6:0]   = OPC_OP_IMM;
            end
            8: begin                               // Shifts by immediate
                w[31:25] = (!pick[0] && pick[1]) ? 7'h20 : 7'h00;
                w[14:12] = pick[0] ? 3'd1 : 3'd5;
                w[6:0]   = OPC_OP_IMM;
            end
            9: begin
                f3       = pick[2:0];
                w[31:25] = (pick[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
                w[14:12] = f3;
                w[6:0]   = OPC_OP;
            end
            10: begin
                case (pick % 3)
                    0:       w[6:0] = 7'b0001111;
                    1:       w[6:0] = 7'b1110011;
                    default: w[6:0] = 7'b0011011;
                endcase
            end
            default: begin
                case (pick % 4)
                    0:       w[14:0] = {3'b011, r[11:7], OPC_BRANCH};
                    1:       w[14:0] = {3'b111, r[11:7], OPC_LOAD};
                    2:       w[14:0] = {3'b100, r[11:7], OPC_STORE};
                    default: w = {7'h01, r[24:7], OPC_OP};  // Multiply is not kept
                endcase
            end
        endcase
        return w;
    endfunction

    task automatic drive_cycle(input int ready_pct, input bit allow_redirect);
        @(posedge g_clk);
        #2;
        if (redirect) begin
            redirect = 1'b0;                       // One cycle pulse
        end else if (allow_redirect && $urandom_range(99) < 6) begin
            redirect        = 1'b1;
            redirect_target = $urandom & 32'hffff_fffc;
        end
        uop_ready = !redirect && ($urandom_range(99) < ready_pct);
        if (!fetch_valid || fetch_taken) begin
            fetch_valid      = ($urandom_range(99) < 85);
            fetch_word.instr = make_word($urandom_range(11), $urandom, $urandom);
            fetch_word.ferr  = ($urandom_range(99) < 8);
        end
    endtask

    //----------------------------------------
    // Scoreboard and compare
    //----------------------------------------
    always @(negedge g_clk) begin
        if (g_resetn) begin
            check_eq("uop_valid", exp_q.size() != 0, uop_valid);
            check_eq("fetch_ready", (exp_q.size() < 2) && !redirect, fetch_ready);
            if (redirect) begin
                exp_q.delete();                    // Buffer flushed at this edge
                exp_pc      = redirect_target;
                fetch_taken = 1'b0;
            end else begin
                if (uop_valid && uop_ready) begin
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("Micro-op handed out with nothing expected");
                    end else begin
                        exp_uop = exp_q.pop_front();
                        compare_uop(exp_uop, uop, n_out);
                        n_out++;
                    end
                end
                fetch_taken = fetch_valid && fetch_ready;
                if (fetch_taken) begin
                    check_eq("rs1_addr", fetch_bits[19:15], rs1_addr);
                    check_eq("rs2_addr", fetch_bits[24:20], rs2_addr);
                    exp_q.push_back(ref_decode(fetch_word, exp_pc, regs[fetch_bits[19:15]],
                                               regs[fetch_bits[24:20]]));
                    exp_pc = exp_pc + 32'd4;
                end
            end
        end
    end

    always @(posedge g_clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //----------------------------------------
    // Main sequence
    //----------------------------------------
    initial begin
        void'($urandom(25129));
        for (int i = 0; i < 32; i++) begin
            regs[i] = $urandom;
        end
        fetch_valid     = 1'b0;
        fetch_word      = '0;
        redirect        = 1'b0;
        redirect_target = '0;
        uop_ready       = 1'b0;
        exp_pc          = RESET_PC;
        fetch_taken     = 1'b0;
        errors          = 0;
        checks          = 0;
        n_out           = 0;
        cycle_cnt       = 0;

        while (g_resetn !== 1'b1) @(posedge g_clk);
        repeat (PHASE_CYCLES) drive_cycle(100, 1'b0);   // Full throughput
        repeat (PHASE_CYCLES) drive_cycle(45, 1'b0);    // Back-pressure
        repeat (PHASE_CYCLES) drive_cycle(70, 1'b1);    // With redirects

        // Drain
        @(posedge g_clk);
        #2;
        redirect  = 1'b0;
        uop_ready = 1'b1;
        while (fetch_valid && !fetch_taken) begin
            @(posedge g_clk);
            #2;
        end
        fetch_valid = 1'b0;
        while (exp_q.size() != 0 || uop_valid) begin
            @(posedge g_clk);
            #2;
        end
        repeat (2) @(posedge g_clk);

        if (n_out == 0) begin
            errors++;
            $display("No micro-ops were compared");
        end
        $display("Checks: %0d, errors: %0d, micro-ops compared: %0d", checks, errors, n_out);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
